// File: design/chn_cfg.svh
// --------------------
// Channel configuration macros
// BAR number, register offsets and event counter width
// --------------------

`ifndef CHN_CFG_SVH
`define CHN_CFG_SVH

// BAR whose hit bit marks channel traffic
`define CHN_BARHIT 2

// Register map, dword offsets inside the BAR
`define CHN_BARMP_IRQ_EN  6'b001100     // Write 1 to enable irq
`define CHN_BARMP_IRQ_DIS 6'b001101     // Write 1 to disable irq
`define CHN_BARMP_IRQ_THR 6'b001110     // Event threshold

// Event counter and threshold width
`define CHN_IRQ_CNT_W 16

`endif

// File: design/trn_pkg.sv
// --------------------
// TRN bus types
// Receive beat struct and TLP format/type codes
// --------------------

package trn_pkg;

    // One beat of the TRN receive bus, strobes active low
    typedef struct packed {
        logic [63:0] rd;                // Payload
        logic [7:0]  rrem_n;            // Byte remainder
        logic        rsof_n;            // Start of TLP
        logic        reof_n;            // End of TLP
        logic        rsrc_rdy_n;        // Beat valid
        logic [6:0]  rbar_hit_n;        // One bit per BAR
    } trn_rx_beat_t;

    // Fmt and type fields as found in bits 62:56 of beat 0
    typedef enum logic [6:0] {
        MRD32 = 7'b00_00000,            // 3DW read
        MWR32 = 7'b10_00000,            // 3DW write with data
        MWR64 = 7'b11_00000,            // 4DW write with data
        CPLD  = 7'b10_01010             // Completion with data
    } tlp_fmt_e;

endpackage

// File: design/chn_pkg.sv
// --------------------
// Channel types
// Register writes, endpoint bundles, FSM states
// --------------------

package chn_pkg;

    // Register targeted by a BAR write
    typedef enum logic [1:0] {
        REG_NONE    = 2'd0,             // No match
        REG_IRQ_EN  = 2'd1,
        REG_IRQ_DIS = 2'd2,
        REG_IRQ_THR = 2'd3
    } reg_sel_e;

    // Decoded register write, valid for one cycle
    typedef struct packed {
        logic        valid;
        reg_sel_e    sel;
        logic [31:0] data;
    } reg_wr_t;

    // One bit per endpoint user, for request, drive and grant
    typedef struct packed {
        logic tx;
        logic rx;
        logic irq;
    } ep_req_t;

    // Interrupt controller FSM
    typedef enum logic [1:0] {
        IRQ_IDLE,                       // Wait for threshold
        IRQ_REQ,                        // Ask for the endpoint
        IRQ_SEND                        // Hold cfg_interrupt_n low
    } irq_state_e;

    // Endpoint arbiter FSM, one state per owner
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_TX,
        ARB_RX,
        ARB_IRQ
    } arb_state_e;

endpackage

// File: design/bar_decode.sv
// --------------------
// bar_decode
// Turns 32-bit memory writes on the channel BAR into register writes
// --------------------

`timescale 1ns/1ps
`include "chn_cfg.svh"

module bar_decode import trn_pkg::*, chn_pkg::*; (
    input  logic         pcie_clk,
    input  logic         arst_n,
    input  trn_rx_beat_t trn_rx,       // TRN receive beat
    output reg_wr_t      reg_wr        // One-cycle register write
);

    logic        beat_vld;             // Beat present on the bus
    logic        hdr_ok;               // Beat 0 fields qualify
    logic        hdr_hit;              // Qualifying beat 0 seen
    logic [5:0]  dw_off;               // Dword offset from beat 1
    reg_sel_e    dec_sel;              // Decoded register
    logic        wr_vld_q;
    reg_sel_e    wr_sel_q;
    logic [31:0] wr_data_q;

    assign beat_vld = !trn_rx.rsrc_rdy_n;
    assign hdr_ok   = (tlp_fmt_e'(trn_rx.rd[62:56]) == MWR32) &&
                      !trn_rx.rbar_hit_n[`CHN_BARHIT];
    assign dw_off   = trn_rx.rd[39:34];                    // Address bits 7:2

    // --------------------
    // Offset decode
    // --------------------
    always_comb begin
        case (dw_off)
            `CHN_BARMP_IRQ_EN:  dec_sel = REG_IRQ_EN;
            `CHN_BARMP_IRQ_DIS: dec_sel = REG_IRQ_DIS;
            `CHN_BARMP_IRQ_THR: dec_sel = REG_IRQ_THR;
            default:            dec_sel = REG_NONE;        // Unknown offset, dropped
        endcase
    end

    // Header tracking and write strobe
    always_ff @(posedge pcie_clk or negedge arst_n) begin
        if (!arst_n) begin
            hdr_hit  <= 1'b0;
            wr_vld_q <= 1'b0;
            wr_sel_q <= REG_NONE;
        end else begin
            wr_vld_q <= 1'b0;                              // Pulse by default
            if (beat_vld && !trn_rx.rsof_n) begin
                hdr_hit <= hdr_ok;                         // Remember beat 0
            end else if (beat_vld && !trn_rx.reof_n) begin
                hdr_hit  <= 1'b0;                          // TLP done
                wr_vld_q <= hdr_hit && (dec_sel != REG_NONE);
                wr_sel_q <= dec_sel;
            end
        end
    end

    // Write data, payload only
    always_ff @(posedge pcie_clk) begin
        if (beat_vld && !trn_rx.reof_n) begin
            wr_data_q <= trn_rx.rd[31:0];
        end
    end

    assign reg_wr = '{valid: wr_vld_q, sel: wr_sel_q, data: wr_data_q};

    // At most one register write per two-beat TLP
    a_wr_pulse: assert property (@(posedge pcie_clk) disable iff (!arst_n)
        reg_wr.valid |=> !reg_wr.valid);

endmodule

// File: design/irq_ctrl.sv
// --------------------
// irq_ctrl
// Interrupt enable, threshold and event counter
// Requests the endpoint and drives cfg_interrupt_n
// --------------------

`timescale 1ns/1ps
`include "chn_cfg.svh"

module irq_ctrl import chn_pkg::*; (
    input  logic    pcie_clk,
    input  logic    arst_n,
    input  reg_wr_t reg_wr,            // From bar_decode
    input  logic    tx_send_irq,       // Event pulses
    input  logic    rx_send_irq,
    input  logic    my_trn,            // Endpoint grant
    output logic    req_ep,
    output logic    drv_ep,
    output logic    cfg_interrupt_n,
    input  logic    cfg_interrupt_rdy_n
);

    localparam int CNT_W = `CHN_IRQ_CNT_W;

    irq_state_e       state;
    logic             irq_en;          // Interrupts allowed
    logic [CNT_W-1:0] irq_thr;         // Events per interrupt
    logic [CNT_W-1:0] evt_cnt;         // Events since last irq
    logic [1:0]       evt_num;         // Events this cycle
    logic [CNT_W:0]   cnt_sum;         // One extra bit for overflow
    logic [CNT_W-1:0] cnt_sat;
    logic             irq_due;
    logic             irq_ack;         // Endpoint took the interrupt

    assign evt_num = {1'b0, tx_send_irq} + {1'b0, rx_send_irq};
    assign cnt_sum = {1'b0, evt_cnt} + {{(CNT_W-1){1'b0}}, evt_num};
    assign cnt_sat = cnt_sum[CNT_W] ? {CNT_W{1'b1}} : cnt_sum[CNT_W-1:0];
    assign irq_due = irq_en && (irq_thr != '0) && (evt_cnt >= irq_thr);
    assign irq_ack = (state == IRQ_SEND) && !cfg_interrupt_rdy_n;

    // --------------------
    // Registers and counter
    // --------------------
    always_ff @(posedge pcie_clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_en  <= 1'b0;
            irq_thr <= '0;
            evt_cnt <= '0;
        end else begin
            if (reg_wr.valid) begin
                case (reg_wr.sel)
                    REG_IRQ_EN:  if (reg_wr.data[0]) irq_en <= 1'b1;
                    REG_IRQ_DIS: if (reg_wr.data[0]) irq_en <= 1'b0;
                    REG_IRQ_THR: irq_thr <= reg_wr.data[CNT_W-1:0];
                    default:     ;                         // Nothing to update
                endcase
            end
            if (irq_ack) begin
                evt_cnt <= {{(CNT_W-2){1'b0}}, evt_num};   // Restart with same-cycle events
            end else begin
                evt_cnt <= cnt_sat;                        // Saturating count
            end
        end
    end

    // --------------------
    // Interrupt FSM
    // --------------------
    always_ff @(posedge pcie_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IRQ_IDLE;
        end else begin
            case (state)
                IRQ_IDLE: if (irq_due) state <= IRQ_REQ;
                IRQ_REQ:  if (my_trn)  state <= IRQ_SEND;   // Endpoint is ours
                IRQ_SEND: if (irq_ack) state <= IRQ_IDLE;
                default:  state <= IRQ_IDLE;
            endcase
        end
    end

    assign req_ep          = (state == IRQ_REQ);
    assign drv_ep          = (state == IRQ_SEND);
    assign cfg_interrupt_n = (state != IRQ_SEND);          // Active low

    // Interrupt line held low until the endpoint accepts it
    a_int_hold: assert property (@(posedge pcie_clk) disable iff (!arst_n)
        !cfg_interrupt_n && cfg_interrupt_rdy_n |=> !cfg_interrupt_n);

    // Arbiter keeps the grant while the endpoint is driven
    a_drv_granted: assert property (@(posedge pcie_clk) disable iff (!arst_n)
        drv_ep |-> my_trn);

endmodule

// File: design/ep_arb.sv
// --------------------
// ep_arb
// Round-robin ownership of the shared endpoint among tx, rx and irq
// --------------------

`timescale 1ns/1ps

module ep_arb import chn_pkg::*; (
    input  logic    pcie_clk,
    input  logic    arst_n,
    input  ep_req_t req,               // Request levels
    input  ep_req_t drv,               // Drive levels
    output ep_req_t trn,               // Grants
    input  logic    chn_trn,           // Endpoint granted to this channel
    output logic    chn_reqep,
    output logic    chn_drvn
);

    arb_state_e state;
    arb_state_e last_own;              // Most recent owner
    arb_state_e nxt_own;               // Winner if granted now
    logic       own_req;
    logic       own_drv;

    // Next requester after the last owner, order tx, rx, irq
    function automatic arb_state_e rr_pick(arb_state_e last, ep_req_t r);
        arb_state_e pick;
        pick = ARB_IDLE;
        case (last)
            ARB_TX: begin
                if (r.rx)       pick = ARB_RX;
                else if (r.irq) pick = ARB_IRQ;
                else if (r.tx)  pick = ARB_TX;
            end
            ARB_RX: begin
                if (r.irq)      pick = ARB_IRQ;
                else if (r.tx)  pick = ARB_TX;
                else if (r.rx)  pick = ARB_RX;
            end
            default: begin                                 // After irq
                if (r.tx)       pick = ARB_TX;
                else if (r.rx)  pick = ARB_RX;
                else if (r.irq) pick = ARB_IRQ;
            end
        endcase
        return pick;
    endfunction

    assign nxt_own = rr_pick(last_own, req);

    // Current owner's levels
    always_comb begin
        case (state)
            ARB_TX:  begin own_req = req.tx;  own_drv = drv.tx;  end
            ARB_RX:  begin own_req = req.rx;  own_drv = drv.rx;  end
            ARB_IRQ: begin own_req = req.irq; own_drv = drv.irq; end
            default: begin own_req = 1'b0;    own_drv = 1'b0;    end
        endcase
    end

    // --------------------
    // Ownership FSM
    // --------------------
    always_ff @(posedge pcie_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ARB_IDLE;
            last_own <= ARB_IRQ;                           // tx wins first
        end else begin
            if (state == ARB_IDLE) begin
                if (chn_trn && (nxt_own != ARB_IDLE)) begin
                    state    <= nxt_own;
                    last_own <= nxt_own;
                end
            end else if (!(chn_trn && (own_req || own_drv))) begin
                state <= ARB_IDLE;                         // Owner done or endpoint lost
            end
        end
    end

    assign trn       = '{tx: state == ARB_TX, rx: state == ARB_RX, irq: state == ARB_IRQ};
    assign chn_reqep = req.tx || req.rx || req.irq;
    assign chn_drvn  = own_drv;

    a_grant_onehot: assert property (@(posedge pcie_clk) disable iff (!arst_n)
        $onehot0(trn));

endmodule

// File: design/chn.sv
// --------------------
// chn
// DMA channel top, BAR decode, interrupt control, endpoint arbiter
// --------------------

`timescale 1ns/1ps

module chn import trn_pkg::*, chn_pkg::*; (
    input  logic         pcie_clk,
    input  logic         arst_n,
    // TRN rx
    input  trn_rx_beat_t trn_rx,
    // Engine events and endpoint levels
    input  logic         tx_send_irq,
    input  logic         rx_send_irq,
    input  ep_req_t      eng_req,      // irq bit unused
    input  ep_req_t      eng_drv,      // irq bit unused
    output ep_req_t      eng_trn,
    // EP arb
    input  logic         chn_trn,
    output logic         chn_reqep,
    output logic         chn_drvn,
    // CFG
    output logic         cfg_interrupt_n,
    input  logic         cfg_interrupt_rdy_n
);

    reg_wr_t reg_wr;                   // Decode to irq
    logic    irq_req;
    logic    irq_drv;
    ep_req_t arb_req;
    ep_req_t arb_drv;
    ep_req_t arb_trn;

    // Engine bits plus the local irq requester
    assign arb_req = '{tx: eng_req.tx, rx: eng_req.rx, irq: irq_req};
    assign arb_drv = '{tx: eng_drv.tx, rx: eng_drv.rx, irq: irq_drv};
    assign eng_trn = arb_trn;

    // --------------------
    // Stages
    // --------------------
    bar_decode u_decode (
        .pcie_clk            (pcie_clk),
        .arst_n              (arst_n),
        .trn_rx              (trn_rx),
        .reg_wr              (reg_wr)
    );

    irq_ctrl u_irq (
        .pcie_clk            (pcie_clk),
        .arst_n              (arst_n),
        .reg_wr              (reg_wr),
        .tx_send_irq         (tx_send_irq),
        .rx_send_irq         (rx_send_irq),
        .my_trn              (arb_trn.irq),
        .req_ep              (irq_req),
        .drv_ep              (irq_drv),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n)
    );

    ep_arb u_arb (
        .pcie_clk            (pcie_clk),
        .arst_n              (arst_n),
        .req                 (arb_req),
        .drv                 (arb_drv),
        .trn                 (arb_trn),
        .chn_trn             (chn_trn),
        .chn_reqep           (chn_reqep),
        .chn_drvn            (chn_drvn)
    );

endmodule

// File: verif/chn_tb.sv
// --------------------
// chn testbench
// Clock, reset, stimulus table, reference model
// Compare tasks and cycle limit
// --------------------

`timescale 1ns/1ps
`include "chn_cfg.svh"

module chn_tb import trn_pkg::*, chn_pkg::*; ();

    localparam int NUM_ROWS = 21;
    localparam int SETTLE   = 3;                           // Cycles before level checks
    localparam int WAIT_MAX = 16;                          // Bound on level waits
    localparam int CNT_MAX  = (1 << `CHN_IRQ_CNT_W) - 1;

    typedef enum logic [1:0] {OP_TLP, OP_EVT, OP_ENG, OP_ACK} op_e;

    // One stimulus step and its expected result
    typedef struct packed {
        op_e         op;
        tlp_fmt_e    fmt;
        int          bar;                                  // BAR hit index
        logic [5:0]  off;                                  // Dword offset
        logic [31:0] data;
        int          num;                                  // Events or drive cycles
        ep_req_t     req_on;                               // Engine requests raised
        ep_req_t     grant;                                // Expected owner
        logic        exp_irq;                              // chn_reqep after the step
    } row_t;

    logic         pcie_clk = 1'b0;
    logic         arst_n;
    trn_rx_beat_t trn_rx;
    logic         tx_send_irq;
    logic         rx_send_irq;
    ep_req_t      eng_req;
    ep_req_t      eng_drv;
    ep_req_t      eng_trn;
    logic         chn_trn;
    logic         chn_reqep;
    logic         chn_drvn;
    logic         cfg_interrupt_n;
    logic         cfg_interrupt_rdy_n;

    row_t rows [NUM_ROWS];
    int   seed = 29;
    int   cycle_cnt = 0;
    int   cycle_limit = 0;
    logic m_en;                                            // Model enable
    int   m_thr;                                           // Model threshold
    int   m_cnt;                                           // Model event count
    logic ack_now;                                         // rdy sampled low this edge

    always #10 pcie_clk = ~pcie_clk;                       // 20 ns period

    chn u_dut (.*);

    // --------------------
    // Failure and compare
    // --------------------
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_grant(string name, ep_req_t got, ep_req_t exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h",
                                             name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h",
                                             name, got, exp));
    endtask

    always @(posedge pcie_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
            abort_run($sformatf("Timeout after %0d cycles", cycle_limit));
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic logic model_due();
        return m_en && (m_thr != 0) && (m_cnt >= m_thr);
    endfunction

    // One clock, model follows the inputs sampled at the edge
    task automatic tick();
        int ev;
        @(posedge pcie_clk);
        ev = int'(tx_send_irq) + int'(rx_send_irq);
        if (ack_now) m_cnt = ev;                           // Reload on acknowledge
        else if (m_cnt + ev > CNT_MAX) m_cnt = CNT_MAX;    // Saturate
        else m_cnt = m_cnt + ev;
        #1;                                                // Drive point
    endtask

    task automatic wait_grant();
        int n;
        n = 0;
        while (eng_trn == '0) begin
            if (n == WAIT_MAX) abort_run("Endpoint grant never appeared");
            tick();
            n++;
        end
    endtask

    task automatic wait_int_low();
        int n;
        n = 0;
        while (cfg_interrupt_n !== 1'b0) begin
            if (n == WAIT_MAX) abort_run("cfg_interrupt_n was never driven low");
            tick();
            n++;
        end
    endtask

    // --------------------
    // Row operations
    // --------------------
    task automatic send_tlp(row_t r);
        logic [31:0] addr;
        chn_trn = 1'b0;
        addr = 32'hF000_0000 | {24'h0, r.off, 2'b00};
        trn_rx.rsrc_rdy_n = 1'b0;                          // Beat 0, header
        trn_rx.rsof_n     = 1'b0;
        trn_rx.rbar_hit_n = ~(7'b1 << r.bar);
        trn_rx.rd         = {1'b0, r.fmt, 56'h0};
        tick();
        trn_rx.rsof_n = 1'b1;                              // Beat 1, address and data
        trn_rx.reof_n = 1'b0;
        trn_rx.rd     = {addr, r.data};
        tick();
        trn_rx = '{rd: '0, rrem_n: '0, rsof_n: 1'b1, reof_n: 1'b1,
                   rsrc_rdy_n: 1'b1, rbar_hit_n: 7'h7F};
        if (r.fmt == MWR32 && r.bar == `CHN_BARHIT) begin  // Accepted writes only
            if (r.off == `CHN_BARMP_IRQ_EN && r.data[0]) m_en = 1'b1;
            else if (r.off == `CHN_BARMP_IRQ_DIS && r.data[0]) m_en = 1'b0;
            else if (r.off == `CHN_BARMP_IRQ_THR) m_thr = int'(r.data) & CNT_MAX;
        end
    endtask

    task automatic pulse_events(row_t r);
        int i;
        int gap;
        chn_trn = 1'b0;
        for (i = 0; i < r.num; i++) begin
            if ($random(seed) & 1) tx_send_irq = 1'b1;     // Random source
            else rx_send_irq = 1'b1;
            tick();
            tx_send_irq = 1'b0;
            rx_send_irq = 1'b0;
            gap = $random(seed) & 3;
            repeat (gap) tick();
        end
    endtask

    // Grant to tx or rx, drive for num cycles, then release
    task automatic run_engine(row_t r);
        eng_req.tx = eng_req.tx | r.req_on.tx;
        eng_req.rx = eng_req.rx | r.req_on.rx;
        chn_trn    = 1'b1;
        wait_grant();
        check_grant("eng_trn", eng_trn, r.grant);
        if (r.grant.tx) eng_drv.tx = 1'b1;
        else eng_drv.rx = 1'b1;
        repeat (r.num) begin
            tick();
            check_grant("eng_trn", eng_trn, r.grant);      // Held while driving
            check_bit("chn_drvn", chn_drvn, 1'b1);
        end
        if (r.grant.tx) eng_req.tx = 1'b0;
        else eng_req.rx = 1'b0;
        eng_drv = '{tx: 1'b0, rx: 1'b0, irq: 1'b0};
        tick();
        check_grant("eng_trn", eng_trn, '0);               // Idle one cycle later
        check_bit("chn_drvn", chn_drvn, 1'b0);
    endtask

    task automatic acknowledge_irq(row_t r);
        int gap;
        chn_trn = 1'b1;
        wait_grant();
        check_grant("eng_trn", eng_trn, r.grant);
        wait_int_low();
        check_bit("chn_drvn", chn_drvn, 1'b1);
        gap = $random(seed) & 3;                           // Late rdy
        repeat (gap) begin
            tick();
            check_bit("cfg_interrupt_n", cfg_interrupt_n, 1'b0);
        end
        cfg_interrupt_rdy_n = 1'b0;
        tx_send_irq = (r.num > 0);                         // Same-cycle events
        rx_send_irq = (r.num > 1);
        ack_now = 1'b1;
        tick();
        ack_now = 1'b0;
        cfg_interrupt_rdy_n = 1'b1;
        tx_send_irq = 1'b0;
        rx_send_irq = 1'b0;
        chn_trn = 1'b0;
        tick();
        check_bit("cfg_interrupt_n", cfg_interrupt_n, 1'b1);
        check_grant("eng_trn", eng_trn, '0);
    endtask

    task automatic check_levels(row_t r, int idx);
        repeat (SETTLE) tick();
        if (model_due() != r.exp_irq)
            abort_run($sformatf("Reference model disagrees with table row %0d", idx));
        check_bit("chn_reqep", chn_reqep, r.exp_irq);
        check_bit("cfg_interrupt_n", cfg_interrupt_n, 1'b1);
        check_bit("chn_drvn", chn_drvn, 1'b0);
        check_grant("eng_trn", eng_trn, '0);
    endtask

    // --------------------
    // Table
    // --------------------
    function automatic row_t tlp_row(tlp_fmt_e fmt, int bar, logic [5:0] off,
                                     logic [31:0] data, logic exp);
        row_t r;
        r = '0;
        r.op = OP_TLP;
        r.fmt = fmt;
        r.bar = bar;
        r.off = off;
        r.data = data;
        r.exp_irq = exp;
        return r;
    endfunction

    function automatic row_t evt_row(int num, logic exp);
        row_t r;
        r = '0;
        r.op = OP_EVT;
        r.num = num;
        r.exp_irq = exp;
        return r;
    endfunction

    function automatic row_t eng_row(ep_req_t req_on, ep_req_t grant, int hold);
        row_t r;
        r = '0;
        r.op = OP_ENG;
        r.req_on = req_on;
        r.grant = grant;
        r.num = hold;
        return r;
    endfunction

    function automatic row_t ack_row(int num, logic exp);
        row_t r;
        r = '0;
        r.op = OP_ACK;
        r.num = num;
        r.grant = '{tx: 1'b0, rx: 1'b0, irq: 1'b1};
        r.exp_irq = exp;
        return r;
    endfunction

    function automatic int row_cycles(row_t r);
        case (r.op)
            OP_TLP:  return 2 + SETTLE;
            OP_EVT:  return 4 * r.num + SETTLE;
            OP_ENG:  return r.num + 6;
            default: return 16;
        endcase
    endfunction

    task automatic build_table();
        rows[0]  = tlp_row(MWR32, 1, `CHN_BARMP_IRQ_EN, 32'h1, 1'b0);           // Wrong BAR
        rows[1]  = tlp_row(MWR64, `CHN_BARHIT, `CHN_BARMP_IRQ_EN, 32'h1, 1'b0); // Wrong type
        rows[2]  = tlp_row(MWR32, `CHN_BARHIT, 6'h3F, 32'h1, 1'b0);             // Bad offset
        rows[3]  = tlp_row(MWR32, `CHN_BARHIT, `CHN_BARMP_IRQ_THR, 32'h8, 1'b0);
        rows[4]  = evt_row(3, 1'b0);                                            // Disabled
        rows[5]  = tlp_row(MWR32, `CHN_BARHIT, `CHN_BARMP_IRQ_EN, 32'h1, 1'b0);
        rows[6]  = evt_row(5, 1'b1);                                            // Count 8
        rows[7]  = ack_row(0, 1'b0);
        rows[8]  = tlp_row(MWR32, `CHN_BARHIT, `CHN_BARMP_IRQ_THR, 32'h3, 1'b0);
        rows[9]  = evt_row(3, 1'b1);
        rows[10] = evt_row(2, 1'b1);                                            // While pending
        rows[11] = ack_row(1, 1'b0);                                            // Reload to 1
        rows[12] = evt_row(1, 1'b0);
        rows[13] = evt_row(1, 1'b1);
        rows[14] = eng_row('{tx: 1'b1, rx: 1'b1, irq: 1'b0}, '{tx: 1'b1, rx: 1'b0, irq: 1'b0}, 3);
        rows[15] = eng_row('0, '{tx: 1'b0, rx: 1'b1, irq: 1'b0}, 2);
        rows[16] = ack_row(2, 1'b0);                                            // Irq last
        rows[17] = tlp_row(MWR32, `CHN_BARHIT, `CHN_BARMP_IRQ_DIS, 32'h1, 1'b0);
        rows[18] = evt_row(4, 1'b0);                                            // Count 6
        rows[19] = tlp_row(MWR32, `CHN_BARHIT, `CHN_BARMP_IRQ_EN, 32'h1, 1'b1);
        rows[20] = ack_row(0, 1'b0);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int i;
        int total;
        arst_n = 1'b0;
        trn_rx = '{rd: '0, rrem_n: '0, rsof_n: 1'b1, reof_n: 1'b1,
                   rsrc_rdy_n: 1'b1, rbar_hit_n: 7'h7F};
        tx_send_irq = 1'b0;
        rx_send_irq = 1'b0;
        eng_req = '0;
        eng_drv = '0;
        chn_trn = 1'b0;
        cfg_interrupt_rdy_n = 1'b1;
        m_en = 1'b0;
        m_thr = 0;
        m_cnt = 0;
        ack_now = 1'b0;
        build_table();
        total = 5;                                         // Reset cycles
        for (i = 0; i < NUM_ROWS; i++) total += row_cycles(rows[i]);
        cycle_limit = 20 * total;
        repeat (3) @(posedge pcie_clk);
        #1 arst_n = 1'b1;
        tick();
        check_bit("cfg_interrupt_n", cfg_interrupt_n, 1'b1);   // Reset levels
        check_grant("eng_trn", eng_trn, '0);
        check_bit("chn_reqep", chn_reqep, 1'b0);
        check_bit("chn_drvn", chn_drvn, 1'b0);
        for (i = 0; i < NUM_ROWS; i++) begin
            case (rows[i].op)
                OP_TLP:  send_tlp(rows[i]);
                OP_EVT:  pulse_events(rows[i]);
                OP_ENG:  run_engine(rows[i]);
                default: acknowledge_irq(rows[i]);
            endcase
            if (rows[i].op != OP_ENG) check_levels(rows[i], i);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: nic_chn.f
+incdir+design
design/trn_pkg.sv
design/chn_pkg.sv
design/bar_decode.sv
design/irq_ctrl.sv
design/ep_arb.sv
design/chn.sv
verif/chn_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only -Wall --timing
TOP        = chn_tb
RTL_TOP    = chn
FILELIST   = nic_chn.f
LOG        = sim.log
BIN        = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	$(BIN) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
